/* design/ramio_pkg.sv */
/*
 * shared definitions for the memory-mapped I/O bridge
 * word and byte-enable types, access-type encodings, I/O port addresses
 */

package ramio_pkg;

  // ------------------------------------------------------------------------
  // widths and word types
  // ------------------------------------------------------------------------

  // client data and address width
  localparam int DATA_W = 32;
  // bytes per client word
  localparam int BYTES_W = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BYTES_W-1:0] byte_en_t;

  // ------------------------------------------------------------------------
  // access types
  // ------------------------------------------------------------------------

  // bit 2 selects sign extension, low bits give the size
  typedef enum logic [2:0] {
    RD_NONE = 3'b000,
    RD_BU   = 3'b001,
    RD_HU   = 3'b010,
    RD_B    = 3'b101,
    RD_H    = 3'b110,
    RD_W    = 3'b111
  } read_type_e;

  typedef enum logic [1:0] {
    WR_NONE = 2'b00,
    WR_B    = 2'b01,
    WR_H    = 2'b10,
    WR_W    = 2'b11
  } write_type_e;

  // I/O ports at the top of the address space
  localparam data_t ADDR_LED      = 32'hffff_fffc;
  localparam data_t ADDR_UART_OUT = 32'hffff_fff8;
  // uart status value when nothing is queued or being sent
  localparam data_t UART_IDLE     = 32'hffff_ffff;

endpackage

/* design/ram_if.sv */
/*
 * request and read-data bundle between the bus decoder and the word RAM
 */

`timescale 1ns/1ns

interface ram_if import ramio_pkg::*; #(
  parameter int RAM_ADDR_W = 8
) ();

  logic                  en;
  logic [RAM_ADDR_W-1:0] addr;
  data_t                 wdata;
  // all zero marks a read
  byte_en_t              be;
  // valid the cycle after an enabled read
  data_t                 rdata;

  modport ctrl (output en, output addr, output wdata, output be, input rdata);
  modport mem  (input en, input addr, input wdata, input be, output rdata);

endinterface

/* design/bus_decoder.sv */
/*
 * client-side bus decoder
 * address decode, write laning, read extraction, LED register,
 * uart push path with back-pressure
 */

`timescale 1ns/1ns

module bus_decoder import ramio_pkg::*; #(
  parameter int RAM_ADDR_W = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  data_t       address,
  input  read_type_e  read_type,
  input  write_type_e write_type,
  input  data_t       data_in,
  output data_t       data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic [3:0]  led,
  ram_if.ctrl         ram,
  output logic        push_valid,
  output logic [7:0]  push_byte,
  input  logic        fifo_full,
  input  logic        tx_busy,
  input  logic [7:0]  tx_byte
);

  // ------------------------------------------------------------------------
  // decode of the held request
  // ------------------------------------------------------------------------

  logic     is_led;
  logic     is_uart;
  logic     is_ram;
  logic     is_wr;
  logic     is_rd;
  logic     accept;
  byte_en_t wr_be;
  data_t    wr_data;

  assign is_led  = (address == ADDR_LED);
  assign is_uart = (address == ADDR_UART_OUT);
  assign is_ram  = !is_led && !is_uart;
  // a request carrying a write type is treated as a write
  assign is_wr   = (write_type != WR_NONE);
  assign is_rd   = !is_wr && (read_type != RD_NONE);

  // stall only a uart write into a full queue
  assign busy   = enable && is_uart && is_wr && fifo_full;
  assign accept = enable && !busy;

  // push fires on the same edge as acceptance
  assign push_valid = enable && is_uart && is_wr;
  assign push_byte  = data_in[7:0];

  // data is replicated across lanes and the enables pick the lanes
  always_comb begin
    wr_be   = '0;
    wr_data = data_in;
    unique case (write_type)
      WR_B: begin
        wr_be   = byte_en_t'(4'b0001 << address[1:0]);
        wr_data = {4{data_in[7:0]}};
      end
      WR_H: begin
        // odd offsets leave all enables clear so the write is dropped
        if (!address[0]) wr_be = address[1] ? 4'b1100 : 4'b0011;
        wr_data = {2{data_in[15:0]}};
      end
      WR_W: wr_be = '1;
      default: wr_be = '0;
    endcase
  end

  // no RAM cycle for a dropped misaligned write
  assign ram.en    = accept && is_ram && (is_rd || (wr_be != '0));
  assign ram.addr  = address[RAM_ADDR_W+1:2];
  assign ram.wdata = wr_data;
  // enables stay clear for anything but a write
  assign ram.be    = wr_be;

  // ------------------------------------------------------------------------
  // read return stage one cycle after acceptance
  // ------------------------------------------------------------------------

  read_type_e rd_type_q;
  logic [1:0] lane_q;
  logic       ram_sel_q;
  data_t      io_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out_ready <= 1'b0;
      led            <= 4'b1111;
    end else begin
      data_out_ready <= accept && is_rd;
      // LED is active low and takes the new value at the acceptance edge
      if (accept && is_wr && is_led) led <= data_in[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_rd) begin
      rd_type_q <= read_type;
      lane_q    <= address[1:0];
      ram_sel_q <= is_ram;
      // uart status is sampled at acceptance and LED reads as zero
      if (is_uart) io_q <= tx_busy ? {24'h0, tx_byte} : UART_IDLE;
      else         io_q <= '0;
    end
  end

  // extract and extend from the registered RAM word
  always_comb begin
    logic [7:0]  rd_b;
    logic [15:0] rd_h;
    rd_b     = ram.rdata[8*lane_q +: 8];
    rd_h     = lane_q[1] ? ram.rdata[31:16] : ram.rdata[15:0];
    data_out = '0;
    if (!ram_sel_q) begin
      data_out = io_q;
    end else begin
      unique case (rd_type_q[1:0])
        2'b01: data_out = {{24{rd_type_q[2] & rd_b[7]}}, rd_b};
        // misaligned half word returns zero
        2'b10: data_out = lane_q[0] ? '0 : {{16{rd_type_q[2] & rd_h[15]}}, rd_h};
        2'b11: data_out = ram.rdata;
        default: data_out = '0;
      endcase
    end
  end

endmodule

/* design/word_ram.sv */
/*
 * single-port word RAM
 * per-lane byte writes, registered read data
 */

`timescale 1ns/1ns

module word_ram import ramio_pkg::*; #(
  parameter int RAM_ADDR_W = 8
) (
  input  logic clk,
  ram_if.mem   mem
);

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  data_t words [DEPTH];

  // ------------------------------------------------------------------------
  // write per enabled lane
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (mem.en) begin
      for (int i = 0; i < BYTES_W; i++) begin
        if (mem.be[i]) words[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
      end
    end
  end

  // ------------------------------------------------------------------------
  // read when no lane is enabled
  // ------------------------------------------------------------------------

  // rdata holds its value until the next read
  always_ff @(posedge clk) begin
    if (mem.en && (mem.be == '0)) begin
      mem.rdata <= words[mem.addr];
    end
  end

endmodule

/* design/tx_fifo.sv */
/*
 * byte FIFO between the bus decoder and the uart transmitter
 * circular buffer with read/write pointers and an occupancy count
 */

`timescale 1ns/1ns

module tx_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_valid,
  input  logic [7:0] push_byte,
  output logic       full,
  output logic       not_empty,
  output logic [7:0] head_byte,
  input  logic       pop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [7:0]       buf_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full      = (count == CNT_W'(FIFO_DEPTH));
  assign not_empty = (count != '0);
  assign head_byte = buf_q[rd_ptr];

  // push is refused while full, pop only with data present
  assign do_push = push_valid && !full;
  assign do_pop  = pop && not_empty;

  always_ff @(posedge clk) begin
    if (do_push) buf_q[wr_ptr] <= push_byte;
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

/* design/uart_tx.sv */
/*
 * 8N1 uart serializer
 * pops the FIFO head, bit-period counter and bit index
 */

`timescale 1ns/1ns

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       not_empty,
  input  logic [7:0] head_byte,
  output logic       pop,
  output logic       tx_busy,
  output logic [7:0] tx_byte,
  output logic       uart_tx
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} tx_state_e;

  tx_state_e  state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0] bit_idx;
  logic [7:0] cur_byte;
  logic       bit_done;

  assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // pop when idle, or at the end of a stop bit so frames run back to back
  assign pop = not_empty && ((state == S_IDLE) || ((state == S_STOP) && bit_done));

  // a byte waiting in the queue counts as busy
  assign tx_busy = (state != S_IDLE) || not_empty;
  assign tx_byte = (state != S_IDLE) ? cur_byte : head_byte;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      uart_tx <= 1'b1;
    end else begin
      clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
      if (pop) begin
        // start bit goes out on the next cycle
        state   <= S_START;
        clk_cnt <= '0;
        uart_tx <= 1'b0;
      end else begin
        unique case (state)
          S_IDLE: begin
            clk_cnt <= '0;
            uart_tx <= 1'b1;
          end
          S_START: if (bit_done) begin
            state   <= S_DATA;
            bit_idx <= '0;
            uart_tx <= cur_byte[0];
          end
          S_DATA: if (bit_done) begin
            // lsb first
            if (bit_idx == 3'd7) begin
              state   <= S_STOP;
              uart_tx <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              uart_tx <= cur_byte[bit_idx + 1'b1];
            end
          end
          S_STOP: if (bit_done) state <= S_IDLE;
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) cur_byte <= head_byte;
  end

endmodule

/* design/ramio_top.sv */
/*
 * top level of the I/O bridge
 * decoder, word RAM, uart byte FIFO and transmitter
 */

`timescale 1ns/1ns

module ramio_top import ramio_pkg::*; #(
  parameter int RAM_ADDR_W   = 8,
  parameter int FIFO_DEPTH   = 4,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  data_t       address,
  input  read_type_e  read_type,
  input  write_type_e write_type,
  input  data_t       data_in,
  output data_t       data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic [3:0]  led,
  output logic        uart_tx
);

  // decoder to FIFO
  logic       push_valid;
  logic [7:0] push_byte;
  logic       fifo_full;
  // FIFO to transmitter
  logic       not_empty;
  logic [7:0] head_byte;
  logic       pop;
  // transmitter status back to the decoder
  logic       tx_busy;
  logic [7:0] tx_byte;

  ram_if #(.RAM_ADDR_W(RAM_ADDR_W)) ram_bus ();

  bus_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) u_dec (
    .clk, .rst_n, .enable, .address, .read_type, .write_type, .data_in,
    .data_out, .data_out_ready, .busy, .led,
    .ram(ram_bus.ctrl),
    .push_valid, .push_byte, .fifo_full, .tx_busy, .tx_byte
  );

  word_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
    .clk,
    .mem(ram_bus.mem)
  );

  tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .rst_n, .push_valid, .push_byte,
    .full(fifo_full), .not_empty, .head_byte, .pop
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk, .rst_n, .not_empty, .head_byte, .pop, .tx_busy, .tx_byte, .uart_tx
  );

endmodule

/* tb/ramio_chk.sv */
/*
 * concurrent assertions on the bus decoder handshake
 * bound into every bus_decoder instance
 */

`timescale 1ns/1ns

module ramio_chk import ramio_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        enable,
  input data_t       address,
  input read_type_e  read_type,
  input write_type_e write_type,
  input logic        busy,
  input logic        data_out_ready
);

  // read request taken on this edge
  logic rd_accept;
  assign rd_accept = enable && !busy && (write_type == WR_NONE) && (read_type != RD_NONE);

  // stall only ever comes from a uart write into a full queue
  busy_is_uart_write: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> (enable && (address == ADDR_UART_OUT) && (write_type != WR_NONE)))
    else $error("busy high without a pending uart write");

  // one cycle read latency
  ready_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    rd_accept |=> data_out_ready)
    else $error("data_out_ready missing one cycle after an accepted read");

  // ready is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |=> !data_out_ready)
    else $error("data_out_ready held for two cycles");

endmodule

bind bus_decoder ramio_chk chk0 (
  .clk(clk), .rst_n(rst_n), .enable(enable), .address(address),
  .read_type(read_type), .write_type(write_type), .busy(busy),
  .data_out_ready(data_out_ready)
);

/* tb/ramio_tb.sv */
/*
 * testbench for the I/O bridge
 * clock and reset, request table loop, serial line decoder,
 * watchdog and result line
 */

`timescale 1ns/1ns

module ramio_tb import ramio_pkg::*; ();

  localparam int CLKS_PER_BIT = 8;
  localparam int FIFO_DEPTH   = 4;
  localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;

  // row kinds
  localparam logic [1:0] K_PLAIN    = 2'd0;
  // uart status read while sending must not be all ones
  localparam logic [1:0] K_NOT_IDLE = 2'd1;
  // wait until every queued byte has left the serial line
  localparam logic [1:0] K_DRAIN    = 2'd2;

  typedef struct {
    data_t       addr;
    read_type_e  rd;
    write_type_e wr;
    data_t       wdata;
    data_t       exp;
    logic [1:0]  kind;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        enable;
  data_t       address;
  read_type_e  read_type;
  write_type_e write_type;
  data_t       data_in;
  data_t       data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_tx;

  row_t       rows [$];
  // bytes written to the uart port with the oldest first
  logic [7:0] tx_q [$];
  int         err_data;
  int         err_serial;
  int         err_other;
  logic       saw_busy;

  ramio_top #(.FIFO_DEPTH(FIFO_DEPTH), .CLKS_PER_BIT(CLKS_PER_BIT)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------------

  task automatic queue_write(input data_t addr, input write_type_e wr, input data_t wdata);
    rows.push_back('{addr, RD_NONE, wr, wdata, 32'h0, K_PLAIN});
  endtask

  task automatic queue_read(input data_t addr, input read_type_e rd, input data_t exp,
                            input logic [1:0] kind);
    rows.push_back('{addr, rd, WR_NONE, 32'h0, exp, kind});
  endtask

  task automatic build_table();
    // whole words at several addresses
    queue_write(32'h0000_0010, WR_W, 32'h1234_5678);
    queue_write(32'h0000_0020, WR_W, 32'hdead_beef);
    queue_write(32'h0000_03fc, WR_W, 32'h0bad_f00d);
    queue_read(32'h0000_0010, RD_W, 32'h1234_5678, K_PLAIN);
    queue_read(32'h0000_0020, RD_W, 32'hdead_beef, K_PLAIN);
    queue_read(32'h0000_03fc, RD_W, 32'h0bad_f00d, K_PLAIN);
    // one byte per lane with the upper bits of data_in ignored
    queue_write(32'h0000_0040, WR_B, 32'haaaa_aa81);
    queue_write(32'h0000_0041, WR_B, 32'h5555_557f);
    queue_write(32'h0000_0042, WR_B, 32'h1234_56c3);
    queue_write(32'h0000_0043, WR_B, 32'hffff_ff05);
    queue_read(32'h0000_0040, RD_W, 32'h05c3_7f81, K_PLAIN);
    queue_read(32'h0000_0040, RD_B, 32'hffff_ff81, K_PLAIN);
    queue_read(32'h0000_0040, RD_BU, 32'h0000_0081, K_PLAIN);
    queue_read(32'h0000_0041, RD_B, 32'h0000_007f, K_PLAIN);
    queue_read(32'h0000_0041, RD_BU, 32'h0000_007f, K_PLAIN);
    queue_read(32'h0000_0042, RD_B, 32'hffff_ffc3, K_PLAIN);
    queue_read(32'h0000_0042, RD_BU, 32'h0000_00c3, K_PLAIN);
    queue_read(32'h0000_0043, RD_B, 32'h0000_0005, K_PLAIN);
    queue_read(32'h0000_0043, RD_BU, 32'h0000_0005, K_PLAIN);
    // half words at offsets 0 and 2 and then misaligned accesses
    queue_write(32'h0000_0050, WR_H, 32'h1111_8001);
    queue_write(32'h0000_0052, WR_H, 32'h2222_7abc);
    queue_read(32'h0000_0050, RD_W, 32'h7abc_8001, K_PLAIN);
    queue_read(32'h0000_0050, RD_H, 32'hffff_8001, K_PLAIN);
    queue_read(32'h0000_0050, RD_HU, 32'h0000_8001, K_PLAIN);
    queue_read(32'h0000_0052, RD_H, 32'h0000_7abc, K_PLAIN);
    queue_write(32'h0000_0051, WR_H, 32'h0000_ffff);
    queue_read(32'h0000_0050, RD_W, 32'h7abc_8001, K_PLAIN);
    queue_read(32'h0000_0051, RD_H, 32'h0000_0000, K_PLAIN);
    queue_read(32'h0000_0053, RD_HU, 32'h0000_0000, K_PLAIN);
    // LED register reads as zero
    queue_read(ADDR_LED, RD_W, 32'h0000_0000, K_PLAIN);
    queue_write(ADDR_LED, WR_W, 32'h0000_00a5);
    queue_write(ADDR_LED, WR_B, 32'h0000_0003);
    queue_read(ADDR_LED, RD_W, 32'h0000_0000, K_PLAIN);
    // six bytes overrun the four-deep queue
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_0055);
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_00a3);
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_0000);
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_00ff);
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_003c);
    queue_write(ADDR_UART_OUT, WR_B, 32'h0000_0081);
    queue_read(ADDR_UART_OUT, RD_W, UART_IDLE, K_NOT_IDLE);
    queue_read(ADDR_UART_OUT, RD_W, UART_IDLE, K_DRAIN);
  endtask

  // ------------------------------------------------------------------------
  // one request through the handshake
  // ------------------------------------------------------------------------

  task automatic run_row(input int idx);
    row_t r;
    int   waited;
    r = rows[idx];
    waited = 0;
    if (r.kind == K_DRAIN) begin
      // the last byte leaves the queue at its stop bit so let that bit end
      while (tx_q.size() != 0) @(posedge clk);
      repeat (CLKS_PER_BIT + 2) @(posedge clk);
    end
    @(posedge clk);
    enable     <= 1'b1;
    address    <= r.addr;
    read_type  <= r.rd;
    write_type <= r.wr;
    data_in    <= r.wdata;
    @(negedge clk);
    while (busy) begin
      saw_busy = 1'b1;
      @(negedge clk);
    end
    // busy is low so this edge takes the request
    @(posedge clk);
    enable     <= 1'b0;
    read_type  <= RD_NONE;
    write_type <= WR_NONE;
    if (r.wr != WR_NONE && r.addr == ADDR_UART_OUT) tx_q.push_back(r.wdata[7:0]);
    if (r.wr != WR_NONE && r.addr == ADDR_LED) begin
      @(negedge clk);
      if (led !== r.wdata[3:0]) begin
        $display("Error: led row %0d got %h expected %h", idx, led, r.wdata[3:0]);
        err_data++;
      end
    end
    if (r.wr == WR_NONE) begin
      @(negedge clk);
      while (!data_out_ready && waited < 4) begin
        waited++;
        @(negedge clk);
      end
      if (!data_out_ready) begin
        $display("row %0d read was accepted but data_out_ready never came", idx);
        err_other++;
      end else if (r.kind == K_NOT_IDLE) begin
        if (data_out === UART_IDLE) begin
          $display("Error: data_out row %0d got %h expected not %h", idx, data_out, UART_IDLE);
          err_data++;
        end
      end else if (data_out !== r.exp) begin
        $display("Error: data_out row %0d got %h expected %h", idx, data_out, r.exp);
        err_data++;
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // serial line decoder sampling the middle of each bit
  // ------------------------------------------------------------------------

  initial begin : serial_check
    logic [7:0] rx;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        $display("start bit on uart_tx did not stay low");
        err_serial++;
      end
      // lsb first
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        $display("stop bit on uart_tx was not high");
        err_serial++;
      end
      if (tx_q.size() == 0) begin
        $display("a frame appeared on uart_tx with no byte written");
        err_serial++;
      end else begin
        if (rx !== tx_q[0]) begin
          $display("Error: uart_tx byte got %h expected %h", rx, tx_q[0]);
          err_serial++;
        end
        void'(tx_q.pop_front());
      end
    end
  end

  // every row may cost at most one frame plus handshake cycles
  initial begin : watchdog
    int limit;
    wait (rst_n === 1'b1);
    limit = rows.size() * (FRAME_CLKS + 8) + 200;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    void'($urandom(32'hc293));
    rst_n      = 1'b0;
    enable     = 1'b0;
    address    = '0;
    read_type  = RD_NONE;
    write_type = WR_NONE;
    data_in    = '0;
    err_data   = 0;
    err_serial = 0;
    err_other  = 0;
    saw_busy   = 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (led !== 4'b1111) begin
      $display("Error: led after reset got %h expected %h", led, 4'b1111);
      err_data++;
    end
    if (data_out_ready !== 1'b0) begin
      $display("Error: data_out_ready after reset got %h expected %h", data_out_ready, 1'b0);
      err_data++;
    end
    if (busy !== 1'b0) begin
      $display("Error: busy after reset got %h expected %h", busy, 1'b0);
      err_data++;
    end
    if (uart_tx !== 1'b1) begin
      $display("Error: uart_tx after reset got %h expected %h", uart_tx, 1'b1);
      err_data++;
    end
    for (int i = 0; i < rows.size(); i++) begin
      repeat ($urandom % 3) @(posedge clk);
      run_row(i);
    end
    repeat (4) @(posedge clk);
    if (tx_q.size() != 0) begin
      $display("%0d uart bytes never appeared on uart_tx", tx_q.size());
      err_serial++;
    end
    if (!saw_busy) begin
      $display("busy never rose while the uart queue was full");
      err_other++;
    end
    $display("errors: data %0d, serial %0d, other %0d", err_data, err_serial, err_other);
    if (err_data + err_serial + err_other == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
design/ramio_pkg.sv
design/ram_if.sv
design/bus_decoder.sv
design/word_ram.sv
design/tx_fifo.sv
design/uart_tx.sv
design/ramio_top.sv
tb/ramio_chk.sv
tb/ramio_tb.sv

/* Bender.yml */
package:
  name: ramio

sources:
  - design/ramio_pkg.sv
  - design/ram_if.sv
  - design/bus_decoder.sv
  - design/word_ram.sv
  - design/tx_fifo.sv
  - design/uart_tx.sv
  - design/ramio_top.sv
  - target: test
    files:
      - tb/ramio_chk.sv
      - tb/ramio_tb.sv
